// ==== filelist.f ====
hw/serial_bus_pkg.sv
hw/bus_master.sv
hw/bus_arbiter.sv
hw/bus_interconnect.sv
hw/bus_slave_mem.sv
hw/serial_bus_top.sv
bench/serial_bus_chk.sv
bench/serial_bus_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the serial bus testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module serial_bus_tb \
	-f filelist.f -o serial_bus_sim
status=0
./obj_dir/serial_bus_sim > sim.log 2>&1 || status=$?
cat sim.log
if grep -q "=== FAIL ===" sim.log || [ "$status" -ne 0 ]; then
	exit 1
fi

// ==== bench/serial_bus_tb.sv ====
// serial bus testbench with table-driven commands and a reference memory per slave
`timescale 1ns/1ps

module serial_bus_tb;

	localparam int S0_DEPTH = 4096;
	localparam int S1_DEPTH = 2048;
	localparam int S2_DEPTH = 2048;
	localparam int S2_DELAY = 10;
	localparam int TIMEOUT  = 200;	// cycles allowed per wait

	typedef struct packed {
		logic [1:0]                          mst;	// 1 or 2, 3 pairs with the next entry
		serial_bus_pkg::bus_cmd_t            cmd;
		logic [serial_bus_pkg::DATA_LEN-1:0] exp;	// reads only
	} entry_t;

	logic                     clk;
	logic                     arst_n;
	serial_bus_pkg::bus_cmd_t m1_cmd, m2_cmd;
	logic                     m1_start, m2_start;
	logic                     m1_busy, m2_busy, m1_done, m2_done;
	logic [7:0]               m1_rdata, m2_rdata;
	entry_t                   table_q[$];
	logic [7:0]               ref_mem [3][4096];
	integer                   seed = 32330;

	serial_bus_top #(.S0_DEPTH(S0_DEPTH), .S1_DEPTH(S1_DEPTH), .S2_DEPTH(S2_DEPTH),
		.S2_DELAY(S2_DELAY)) dut0 (
		.clk(clk), .arst_n(arst_n), .m1_cmd(m1_cmd), .m2_cmd(m2_cmd),
		.m1_start(m1_start), .m2_start(m2_start), .m1_busy(m1_busy), .m2_busy(m2_busy),
		.m1_done(m1_done), .m2_done(m2_done), .m1_rdata(m1_rdata), .m2_rdata(m2_rdata)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	function automatic int depth_of(input int slv);
		return (slv == 0) ? S0_DEPTH : (slv == 1) ? S1_DEPTH : S2_DEPTH;
	endfunction

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			stop_run($sformatf("error: %s got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	// expected read data follows the modulo-depth rule
	task automatic add_entry(input int mst, input int wr, input int slv, input int addr,
		input int data);
		entry_t e;
		int     idx;
		idx = addr % depth_of(slv);
		e.mst = 2'(mst);
		e.cmd = {1'(wr), serial_bus_pkg::SLAVE_LEN'(slv), serial_bus_pkg::ADDR_LEN'(addr),
			serial_bus_pkg::DATA_LEN'(data)};
		if (wr != 0)
			ref_mem[slv][idx] = 8'(data);
		e.exp = ref_mem[slv][idx];
		table_q.push_back(e);
	endtask

	task automatic launch(input logic [1:0] who, input serial_bus_pkg::bus_cmd_t c1,
		input serial_bus_pkg::bus_cmd_t c2);
		int n;
		n = 0;
		while ((who[0] && m1_busy) || (who[1] && m2_busy)) begin
			@(posedge clk);
			#1;
			n++;
			if (n > TIMEOUT)
				stop_run("a master stayed busy, the next command could not start");
		end
		m1_cmd   = c1;
		m2_cmd   = c2;
		m1_start = who[0];
		m2_start = who[1];
	endtask

	// busy must hold until each active master's done pulse
	task automatic await_done(input logic [1:0] who, output logic [7:0] rd1,
		output logic [7:0] rd2, output int t1, output int t2);
		logic [1:0] left;
		int         n;
		left = who;
		n    = 0;
		t1   = 0;
		t2   = 0;
		while (left != 2'b00) begin
			@(posedge clk);
			#1;
			m1_start = 1'b0;
			m2_start = 1'b0;
			n++;
			if (left[0]) begin
				check("m1_busy", m1_busy, 1);
				if (m1_done) begin
					rd1     = m1_rdata;
					t1      = n;
					left[0] = 1'b0;
				end
			end
			if (left[1]) begin
				check("m2_busy", m2_busy, 1);
				if (m2_done) begin
					rd2     = m2_rdata;
					t2      = n;
					left[1] = 1'b0;
				end
			end
			if (left != 2'b00 && n > TIMEOUT)
				stop_run("no done pulse from the master within the timeout");
		end
	endtask

	initial begin
		entry_t     e1, e2;
		logic [1:0] who;
		logic [7:0] rd1, rd2;
		int         t1, t2, s, a;
		int         wslv[$];
		int         waddr[$];

		arst_n   = 1'b0;
		m1_cmd   = '0;
		m2_cmd   = '0;
		m1_start = 1'b0;
		m2_start = 1'b0;

		for (s = 0; s < 3; s++) begin	// write then read, both masters
			add_entry(1, 1, s, 'h010 + s, 'h5a ^ s);
			add_entry(1, 0, s, 'h010 + s, 0);
			add_entry(2, 1, s, 'h3c0 + s, 'ha5 + s);
			add_entry(2, 0, s, 'h3c0 + s, 0);
		end
		for (s = 1; s < 3; s++) begin	// 2k slaves wrap at 0x800
			add_entry(1, 1, s, 'h800 + 'h123, 'hc3 + s);
			add_entry(2, 0, s, 'h123, 0);
		end
		add_entry(3, 1, 0, 'h7ff, 'h81);	// same cycle starts
		add_entry(2, 1, 2, 'h456, 'h42);
		add_entry(3, 0, 0, 'h7ff, 0);
		add_entry(2, 0, 2, 'h456, 0);
		for (int k = 0; k < 8; k++) begin
			s = $unsigned($random(seed)) % 3;
			a = $random(seed) & 'hfff;
			wslv.push_back(s);
			waddr.push_back(a);
			add_entry(k % 2 + 1, 1, s, a, $random(seed) & 'hff);
		end
		for (int k = 0; k < 8; k++)
			add_entry(2 - k % 2, 0, wslv[k], waddr[k], 0);

		repeat (5) @(posedge clk);
		#1;
		arst_n = 1'b1;
		check("m1_busy", m1_busy, 0);
		check("m2_busy", m2_busy, 0);
		check("m1_done", m1_done, 0);
		check("m2_done", m2_done, 0);

		for (int i = 0; i < table_q.size(); i++) begin
			e1  = table_q[i];
			e2  = e1;
			who = (e1.mst == 2'd2) ? 2'b10 : (e1.mst == 2'd3) ? 2'b11 : 2'b01;
			if (e1.mst == 2'd3) begin
				i++;
				e2 = table_q[i];
			end
			launch(who, e1.cmd, e2.cmd);
			await_done(who, rd1, rd2, t1, t2);
			if (who[0] && !e1.cmd.write)
				check("m1_rdata", rd1, e1.exp);
			if (who[1] && !e2.cmd.write)
				check("m2_rdata", rd2, e2.exp);
			if (who == 2'b11)
				check("m1_done_before_m2_done", t1 <= t2, 1);	// fixed priority
		end
		$display("=== PASS ===");
		$finish;
	end

endmodule

// ==== bench/serial_bus_chk.sv ====
// bus checker with assertions on arbitration and slave routing, bound to the interconnect
`timescale 1ns/1ps

module serial_bus_chk (
	input logic                                                    clk,
	input logic                                                    arst_n,
	input logic                                                    m1_grant,
	input logic                                                    m2_grant,
	input logic                                                    trans_done,
	input logic [serial_bus_pkg::SLAVE_LEN-1:0]                    active_sel,
	input serial_bus_pkg::bus_m2s_t [serial_bus_pkg::NUM_SLAVES-1:0] s_m2s
);

	grant_excl: assert property (@(posedge clk) disable iff (!arst_n)
		!(m1_grant && m2_grant)) else $error("both masters granted");

	m1_hold: assert property (@(posedge clk) disable iff (!arst_n)
		(m1_grant && !trans_done) |=> m1_grant) else $error("master 1 grant lost early");

	m2_hold: assert property (@(posedge clk) disable iff (!arst_n)
		(m2_grant && !trans_done) |=> m2_grant) else $error("master 2 grant lost early");

	for (genvar i = 0; i < serial_bus_pkg::NUM_SLAVES; i++) begin : g_slave
		route: assert property (@(posedge clk) disable iff (!arst_n)
			(s_m2s[i] != '0) |-> ((m1_grant || m2_grant) &&
			active_sel == serial_bus_pkg::SLAVE_LEN'(i)))
			else $error("slave %0d driven while not the target", i);
	end

endmodule

bind bus_interconnect serial_bus_chk chk0 (
	.clk(clk), .arst_n(arst_n), .m1_grant(m1_grant), .m2_grant(m2_grant),
	.trans_done(trans_done), .active_sel(active_sel), .s_m2s(s_m2s)
);

// ==== hw/serial_bus_top.sv ====
// serial bus top with two masters, the interconnect and three memory slaves
`timescale 1ns/1ps

module serial_bus_top #(
	parameter int S0_DEPTH = 4096,
	parameter int S1_DEPTH = 2048,
	parameter int S2_DEPTH = 2048,
	parameter int S2_DELAY = 10
) (
	input  logic                                clk,
	input  logic                                arst_n,
	input  serial_bus_pkg::bus_cmd_t            m1_cmd,
	input  serial_bus_pkg::bus_cmd_t            m2_cmd,
	input  logic                                m1_start,
	input  logic                                m2_start,
	output logic                                m1_busy,
	output logic                                m2_busy,
	output logic                                m1_done,
	output logic                                m2_done,
	output logic [serial_bus_pkg::DATA_LEN-1:0] m1_rdata,
	output logic [serial_bus_pkg::DATA_LEN-1:0] m2_rdata
);

	logic                                                      m1_req, m2_req;
	logic [serial_bus_pkg::SLAVE_LEN-1:0]                      m1_sel, m2_sel;
	logic                                                      m1_grant, m2_grant;
	logic                                                      m1_trans_done, m2_trans_done;
	serial_bus_pkg::bus_m2s_t                                  m1_m2s, m2_m2s;
	serial_bus_pkg::bus_s2m_t                                  m1_s2m, m2_s2m;
	serial_bus_pkg::bus_m2s_t [serial_bus_pkg::NUM_SLAVES-1:0] s_m2s;
	serial_bus_pkg::bus_s2m_t [serial_bus_pkg::NUM_SLAVES-1:0] s_s2m;

	bus_master m1 (
		.clk(clk), .arst_n(arst_n), .cmd(m1_cmd), .start(m1_start),
		.busy(m1_busy), .done(m1_done), .rdata(m1_rdata),
		.req(m1_req), .sel(m1_sel), .grant(m1_grant), .trans_done(m1_trans_done),
		.m2s(m1_m2s), .s2m(m1_s2m)
	);

	bus_master m2 (
		.clk(clk), .arst_n(arst_n), .cmd(m2_cmd), .start(m2_start),
		.busy(m2_busy), .done(m2_done), .rdata(m2_rdata),
		.req(m2_req), .sel(m2_sel), .grant(m2_grant), .trans_done(m2_trans_done),
		.m2s(m2_m2s), .s2m(m2_s2m)
	);

	bus_interconnect bus0 (
		.clk(clk), .arst_n(arst_n),
		.m1_req(m1_req), .m2_req(m2_req), .m1_sel(m1_sel), .m2_sel(m2_sel),
		.m1_trans_done(m1_trans_done), .m2_trans_done(m2_trans_done),
		.m1_grant(m1_grant), .m2_grant(m2_grant),
		.m1_m2s(m1_m2s), .m2_m2s(m2_m2s), .m1_s2m(m1_s2m), .m2_s2m(m2_s2m),
		.s_m2s(s_m2s), .s_s2m(s_s2m)
	);

	// slave 0, 4k bytes
	bus_slave_mem #(.MEM_DEPTH(S0_DEPTH), .READ_DELAY(0)) slave0 (
		.clk(clk), .arst_n(arst_n), .m2s(s_m2s[0]), .s2m(s_s2m[0])
	);

	bus_slave_mem #(.MEM_DEPTH(S1_DEPTH), .READ_DELAY(0)) slave1 (
		.clk(clk), .arst_n(arst_n), .m2s(s_m2s[1]), .s2m(s_s2m[1])
	);

	// slave 2 answers reads late
	bus_slave_mem #(.MEM_DEPTH(S2_DEPTH), .READ_DELAY(S2_DELAY)) slave2 (
		.clk(clk), .arst_n(arst_n), .m2s(s_m2s[2]), .s2m(s_s2m[2])
	);

endmodule

// ==== hw/bus_slave_mem.sv ====
// memory slave that deserializes requests, stores or reads a byte and returns it serially
`timescale 1ns/1ps

module bus_slave_mem #(
	parameter int MEM_DEPTH  = 4096,
	parameter int READ_DELAY = 0
) (
	input  logic                        clk,
	input  logic                        arst_n,
	input  serial_bus_pkg::bus_m2s_t    m2s,
	output serial_bus_pkg::bus_s2m_t    s2m
);

	localparam int AW     = $clog2(MEM_DEPTH);
	localparam int CNT_W  = $clog2(serial_bus_pkg::ADDR_LEN);
	localparam int DCNT_W = $clog2(serial_bus_pkg::DATA_LEN);
	localparam int DLY_W  = (READ_DELAY > 1) ? $clog2(READ_DELAY) : 1;

	serial_bus_pkg::slave_state_e          state;
	logic [CNT_W-1:0]                      cnt;
	logic [DLY_W-1:0]                      dly_cnt;
	logic                                  is_write;
	logic                                  frame_start;
	logic                                  shift_addr;
	logic [serial_bus_pkg::ADDR_LEN-1:0]   addr_sh;
	logic [serial_bus_pkg::DATA_LEN-1:0]   data_sh;
	logic [serial_bus_pkg::DATA_LEN-1:0]   rbuf;	// byte being returned
	logic [AW-1:0]                         idx;
	logic [serial_bus_pkg::DATA_LEN-1:0]   mem [MEM_DEPTH];

	assign frame_start = (state == serial_bus_pkg::S_IDLE) && m2s.valid &&
		(m2s.write_en || m2s.read_en);
	assign shift_addr  = frame_start || (state == serial_bus_pkg::S_RECV_ADDR && m2s.valid);
	assign idx         = addr_sh[AW-1:0];	// upper bits dropped, addresses wrap

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state    <= serial_bus_pkg::S_IDLE;
			cnt      <= '0;
			dly_cnt  <= '0;
			is_write <= 1'b0;
		end else begin
			case (state)
				serial_bus_pkg::S_IDLE: begin
					if (frame_start) begin	// first address bit taken here
						is_write <= m2s.write_en;
						cnt      <= CNT_W'(1);
						state    <= serial_bus_pkg::S_RECV_ADDR;
					end
				end
				serial_bus_pkg::S_RECV_ADDR: begin
					if (m2s.valid) begin
						if (cnt == CNT_W'(serial_bus_pkg::ADDR_LEN - 1)) begin
							cnt   <= '0;
							state <= is_write ? serial_bus_pkg::S_RECV_DATA
								: serial_bus_pkg::S_STORE;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
				end
				serial_bus_pkg::S_RECV_DATA: begin
					if (m2s.valid) begin
						if (cnt == CNT_W'(serial_bus_pkg::DATA_LEN - 1)) begin
							cnt   <= '0;
							state <= serial_bus_pkg::S_STORE;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
				end
				serial_bus_pkg::S_STORE: begin
					dly_cnt <= '0;
					if (is_write)
						state <= serial_bus_pkg::S_IDLE;
					else if (READ_DELAY == 0)
						state <= serial_bus_pkg::S_SEND_DATA;
					else
						state <= serial_bus_pkg::S_DELAY;
				end
				serial_bus_pkg::S_DELAY: begin
					if (dly_cnt == DLY_W'(READ_DELAY - 1))
						state <= serial_bus_pkg::S_SEND_DATA;
					else
						dly_cnt <= dly_cnt + 1'b1;
				end
				serial_bus_pkg::S_SEND_DATA: begin
					if (cnt == CNT_W'(serial_bus_pkg::DATA_LEN - 1)) begin
						cnt   <= '0;
						state <= serial_bus_pkg::S_IDLE;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= serial_bus_pkg::S_IDLE;
			endcase
		end
	end

	// shift registers, lsb arrives first
	always_ff @(posedge clk) begin
		if (shift_addr)
			addr_sh <= {m2s.addr_bit, addr_sh[serial_bus_pkg::ADDR_LEN-1:1]};
		if (state == serial_bus_pkg::S_RECV_DATA && m2s.valid)
			data_sh <= {m2s.data_bit, data_sh[serial_bus_pkg::DATA_LEN-1:1]};
	end

	always_ff @(posedge clk) begin
		if (state == serial_bus_pkg::S_STORE) begin
			if (is_write)
				mem[idx] <= data_sh;
			else
				rbuf <= mem[idx];
		end
	end

	always_comb begin
		s2m.ready     = (state == serial_bus_pkg::S_IDLE);	// low for the whole request
		s2m.valid     = (state == serial_bus_pkg::S_SEND_DATA);
		s2m.rdata_bit = s2m.valid & rbuf[cnt[DCNT_W-1:0]];
	end

endmodule

// ==== hw/bus_interconnect.sv ====
// bus interconnect that arbitrates the masters and routes the serial lines to the slaves
`timescale 1ns/1ps

module bus_interconnect (
	input  logic                                                    clk,
	input  logic                                                    arst_n,
	input  logic                                                    m1_req,
	input  logic                                                    m2_req,
	input  logic [serial_bus_pkg::SLAVE_LEN-1:0]                    m1_sel,
	input  logic [serial_bus_pkg::SLAVE_LEN-1:0]                    m2_sel,
	input  logic                                                    m1_trans_done,
	input  logic                                                    m2_trans_done,
	output logic                                                    m1_grant,
	output logic                                                    m2_grant,
	input  serial_bus_pkg::bus_m2s_t                                m1_m2s,
	input  serial_bus_pkg::bus_m2s_t                                m2_m2s,
	output serial_bus_pkg::bus_s2m_t                                m1_s2m,
	output serial_bus_pkg::bus_s2m_t                                m2_s2m,
	output serial_bus_pkg::bus_m2s_t [serial_bus_pkg::NUM_SLAVES-1:0] s_m2s,
	input  serial_bus_pkg::bus_s2m_t [serial_bus_pkg::NUM_SLAVES-1:0] s_s2m
);

	logic                                    trans_done;
	logic [serial_bus_pkg::SLAVE_LEN-1:0]    active_sel;	// registered target of the owner
	serial_bus_pkg::bus_m2s_t                gnt_m2s;
	serial_bus_pkg::bus_s2m_t                sel_s2m;

	assign trans_done = m1_trans_done | m2_trans_done;

	bus_arbiter arb0 (
		.clk        (clk),
		.arst_n     (arst_n),
		.m1_req     (m1_req),
		.m2_req     (m2_req),
		.m1_sel     (m1_sel),
		.m2_sel     (m2_sel),
		.trans_done (trans_done),
		.m1_grant   (m1_grant),
		.m2_grant   (m2_grant),
		.active_sel (active_sel)
	);

	// lines of whichever master owns the bus
	always_comb begin
		gnt_m2s = '0;
		if (m1_grant)
			gnt_m2s = m1_m2s;
		else if (m2_grant)
			gnt_m2s = m2_m2s;
	end

	// only the addressed slave sees the owner, the others stay at zero
	always_comb begin
		s_m2s   = '0;
		sel_s2m = '0;
		for (int i = 0; i < serial_bus_pkg::NUM_SLAVES; i++) begin
			if (active_sel == serial_bus_pkg::SLAVE_LEN'(i)) begin
				s_m2s[i] = gnt_m2s;
				sel_s2m  = s_s2m[i];
			end
		end
	end

	assign m1_s2m = m1_grant ? sel_s2m : '0;
	assign m2_s2m = m2_grant ? sel_s2m : '0;	// idle slave ready is hidden too

endmodule

// ==== hw/bus_arbiter.sv ====
// fixed priority bus arbiter that holds its grant until the transaction is done
`timescale 1ns/1ps

module bus_arbiter (
	input  logic                                    clk,
	input  logic                                    arst_n,
	input  logic                                    m1_req,
	input  logic                                    m2_req,
	input  logic [serial_bus_pkg::SLAVE_LEN-1:0]    m1_sel,
	input  logic [serial_bus_pkg::SLAVE_LEN-1:0]    m2_sel,
	input  logic                                    trans_done,
	output logic                                    m1_grant,
	output logic                                    m2_grant,
	output logic [serial_bus_pkg::SLAVE_LEN-1:0]    active_sel
);

	logic granted;

	assign granted = m1_grant | m2_grant;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			m1_grant   <= 1'b0;
			m2_grant   <= 1'b0;
			active_sel <= '0;
		end else if (granted) begin
			// owner keeps the bus until its done pulse
			if (trans_done) begin
				m1_grant <= 1'b0;
				m2_grant <= 1'b0;
			end
		end else if (m1_req) begin	// master 1 wins a tie
			m1_grant   <= 1'b1;
			active_sel <= m1_sel;
		end else if (m2_req) begin
			m2_grant   <= 1'b1;
			active_sel <= m2_sel;
		end
	end

endmodule

// ==== hw/bus_master.sv ====
// bus master that serializes one command onto the bus and collects the read byte
`timescale 1ns/1ps

module bus_master (
	input  logic                                    clk,
	input  logic                                    arst_n,
	input  serial_bus_pkg::bus_cmd_t                cmd,
	input  logic                                    start,
	output logic                                    busy,
	output logic                                    done,
	output logic [serial_bus_pkg::DATA_LEN-1:0]     rdata,
	output logic                                    req,
	output logic [serial_bus_pkg::SLAVE_LEN-1:0]    sel,
	input  logic                                    grant,
	output logic                                    trans_done,
	output serial_bus_pkg::bus_m2s_t                m2s,
	input  serial_bus_pkg::bus_s2m_t                s2m
);

	localparam int CNT_W  = $clog2(serial_bus_pkg::ADDR_LEN);
	localparam int DCNT_W = $clog2(serial_bus_pkg::DATA_LEN);

	serial_bus_pkg::master_state_e         state;
	serial_bus_pkg::bus_cmd_t              cmd_q;	// latched on start
	logic [CNT_W-1:0]                      cnt;	// bit index, address and data
	logic [serial_bus_pkg::DATA_LEN-1:0]   rx_sh;
	logic [serial_bus_pkg::DATA_LEN-1:0]   rx_next;
	logic                                  frame;
	logic                                  last_addr;
	logic                                  last_data;

	assign last_addr = (cnt == CNT_W'(serial_bus_pkg::ADDR_LEN - 1));
	assign last_data = (cnt == CNT_W'(serial_bus_pkg::DATA_LEN - 1));
	assign rx_next   = {s2m.rdata_bit, rx_sh[serial_bus_pkg::DATA_LEN-1:1]};	// lsb first

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= serial_bus_pkg::M_IDLE;
			cnt   <= '0;
		end else begin
			case (state)
				serial_bus_pkg::M_IDLE: begin
					if (start)
						state <= serial_bus_pkg::M_REQUEST;
				end
				serial_bus_pkg::M_REQUEST: begin
					if (grant)
						state <= serial_bus_pkg::M_WAIT_READY;
				end
				serial_bus_pkg::M_WAIT_READY: begin
					if (s2m.ready) begin
						cnt   <= '0;
						state <= serial_bus_pkg::M_SEND_ADDR;
					end
				end
				serial_bus_pkg::M_SEND_ADDR: begin
					if (last_addr) begin
						cnt   <= '0;
						state <= cmd_q.write ? serial_bus_pkg::M_SEND_DATA
							: serial_bus_pkg::M_RECV_DATA;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				serial_bus_pkg::M_SEND_DATA: begin
					if (last_data) begin
						cnt   <= '0;
						state <= serial_bus_pkg::M_DONE;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				serial_bus_pkg::M_RECV_DATA: begin
					// slave may still be counting its read delay
					if (s2m.valid) begin
						if (last_data) begin
							cnt   <= '0;
							state <= serial_bus_pkg::M_DONE;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
				end
				serial_bus_pkg::M_DONE: state <= serial_bus_pkg::M_IDLE;
				default: state <= serial_bus_pkg::M_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == serial_bus_pkg::M_IDLE && start)
			cmd_q <= cmd;
		if (state == serial_bus_pkg::M_RECV_DATA && s2m.valid) begin
			rx_sh <= rx_next;
			if (last_data)
				rdata <= rx_next;	// lands together with done
		end
	end

	assign busy       = (state != serial_bus_pkg::M_IDLE);
	assign done       = (state == serial_bus_pkg::M_DONE);
	assign trans_done = (state == serial_bus_pkg::M_DONE);	// releases the arbiter
	assign req        = (state == serial_bus_pkg::M_REQUEST);
	assign sel        = cmd_q.slave;

	// enables cover the whole frame, reply included
	assign frame = state inside {serial_bus_pkg::M_SEND_ADDR, serial_bus_pkg::M_SEND_DATA,
		serial_bus_pkg::M_RECV_DATA};

	always_comb begin
		m2s.valid    = (state == serial_bus_pkg::M_SEND_ADDR) ||
			(state == serial_bus_pkg::M_SEND_DATA);
		m2s.write_en = frame & cmd_q.write;
		m2s.read_en  = frame & ~cmd_q.write;
		m2s.addr_bit = (state == serial_bus_pkg::M_SEND_ADDR) & cmd_q.addr[cnt];
		m2s.data_bit = (state == serial_bus_pkg::M_SEND_DATA) & cmd_q.data[cnt[DCNT_W-1:0]];
	end

endmodule

// ==== hw/serial_bus_pkg.sv ====
// serial bus package with widths, command and bus structs, and FSM state types
package serial_bus_pkg;

	localparam int SLAVE_LEN  = 2;	// slave number
	localparam int ADDR_LEN   = 12;	// byte address
	localparam int DATA_LEN   = 8;
	localparam int NUM_SLAVES = 3;

	// one complete master command, 23 bits
	typedef struct packed {
		logic                 write;	// 1 write, 0 read
		logic [SLAVE_LEN-1:0] slave;
		logic [ADDR_LEN-1:0]  addr;
		logic [DATA_LEN-1:0]  data;
	} bus_cmd_t;

	// master toward slave, one bit per clock
	typedef struct packed {
		logic valid;
		logic write_en;
		logic read_en;
		logic addr_bit;
		logic data_bit;
	} bus_m2s_t;

	// slave toward master
	typedef struct packed {
		logic ready;
		logic valid;
		logic rdata_bit;
	} bus_s2m_t;

	typedef enum logic [2:0] {
		M_IDLE,
		M_REQUEST,
		M_WAIT_READY,
		M_SEND_ADDR,
		M_SEND_DATA,
		M_RECV_DATA,
		M_DONE
	} master_state_e;

	typedef enum logic [2:0] {
		S_IDLE,
		S_RECV_ADDR,
		S_RECV_DATA,
		S_STORE,
		S_DELAY,
		S_SEND_DATA
	} slave_state_e;

endpackage
